// File: hdl/hyper_pkg.sv
package hyper_pkg;

    localparam int unsigned HYPER_NR_CS   = 2;
    localparam int unsigned HYPER_BURST_W = 12;
    localparam int unsigned HYPER_WAIT_W  = 8;  // latency and recovery counter width

    // host transaction request
    typedef struct packed {
        logic [31:0]              address;  // word address
        logic [HYPER_NR_CS-1:0]   cs;       // one-hot
        logic                     write;
        logic [HYPER_BURST_W-1:0] burst;    // words, 1 and up
    } hyper_trans_t;

    // command-address bit layout, msb first
    typedef struct packed {
        logic        rw_n;       // 1 = read
        logic        reg_space;  // 0 = memory
        logic        linear;     // 1 = linear burst
        logic [28:0] addr_hi;
        logic [12:0] rsvd;
        logic [2:0]  addr_lo;
    } hyper_ca_fields_t;

    // same 48 bits seen as three bus beats, beats[0] goes out first
    typedef union packed {
        hyper_ca_fields_t   fields;
        logic [0:2][15:0]   beats;
    } hyper_ca_u;

    typedef struct packed {
        logic [HYPER_NR_CS-1:0] cs_n;
        logic                   ck_en;
        logic [15:0]            dq;
        logic                   dq_oe;
        logic [1:0]             rwds;     // write byte mask, 1 = masked
        logic                   rwds_oe;
    } hyper_pad_out_t;

    typedef struct packed {
        logic [15:0] dq;
        logic        rwds;  // read word valid
    } hyper_pad_in_t;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        LATENCY,
        WRITE,
        READ,
        RECOVER
    } hyper_phase_e;

endpackage

// File: hdl/hyper_timer.sv
`timescale 1ns/1ps

module hyper_timer (
    input  logic                                 clk0,
    input  logic                                 rst_ni,
    input  logic                                 wait_load_i,
    input  logic [hyper_pkg::HYPER_WAIT_W-1:0]   wait_val_i,
    input  logic                                 burst_load_i,
    input  logic [hyper_pkg::HYPER_BURST_W-1:0]  burst_i,
    input  logic                                 beat_en_i,
    output logic                                 wait_done_o,
    output logic                                 burst_done_o
);
    import hyper_pkg::*;

    logic [HYPER_WAIT_W-1:0]  wait_q;
    logic [HYPER_BURST_W-1:0] beat_q;  // beats left after the current one

    // latency / recovery
    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q <= '0;
        end else if (wait_load_i) begin
            wait_q <= wait_val_i;
        end else if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q <= '0;
        end else if (burst_load_i) begin
            beat_q <= burst_i - 1'b1;
        end else if (beat_en_i && (beat_q != '0)) begin
            beat_q <= beat_q - 1'b1;
        end
    end

    assign wait_done_o  = (wait_q == '0);
    assign burst_done_o = (beat_q == '0);

    // after the last beat the sequencer must leave the data phase
    no_beat_after_done_a: assert property (@(posedge clk0) disable iff (!rst_ni)
        (beat_en_i && burst_done_o) |=> !beat_en_i);

endmodule

// File: hdl/hyper_tx_path.sv
`timescale 1ns/1ps

module hyper_tx_path (
    input  logic                                 clk0,
    input  logic                                 rst_ni,
    input  logic                                 capture_i,
    input  hyper_pkg::hyper_trans_t              trans_i,
    input  hyper_pkg::hyper_phase_e              phase_i,
    input  logic [1:0]                           beat_sel_i,
    input  logic                                 tx_valid_i,
    input  logic [15:0]                          tx_data_i,
    input  logic [1:0]                           tx_strb_i,
    output logic [hyper_pkg::HYPER_NR_CS-1:0]    cs_o,
    output logic                                 write_o,
    output logic [hyper_pkg::HYPER_BURST_W-1:0]  burst_o,
    output logic [15:0]                          dq_o,
    output logic [1:0]                           rwds_o
);
    import hyper_pkg::*;

    logic [31:0]              addr_q;
    logic [HYPER_BURST_W-1:0] burst_q;
    logic [HYPER_NR_CS-1:0]   cs_q;
    logic                     write_q;
    logic                     bus_active;
    hyper_ca_u                ca;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            cs_q    <= '0;
            write_q <= 1'b0;
        end else if (capture_i) begin
            cs_q    <= trans_i.cs;
            write_q <= trans_i.write;
        end
    end

    always_ff @(posedge clk0) begin
        if (capture_i) begin
            addr_q  <= trans_i.address;
            burst_q <= trans_i.burst;
        end
    end

    assign write_o = write_q;
    assign burst_o = burst_q;

    // device selected from first command beat through the last data word
    assign bus_active = phase_i inside {CMD, LATENCY, WRITE, READ};
    assign cs_o       = ~(cs_q & {HYPER_NR_CS{bus_active}});

    always_comb begin
        ca.fields.rw_n      = ~write_q;
        ca.fields.reg_space = 1'b0;
        ca.fields.linear    = 1'b1;
        ca.fields.addr_hi   = addr_q[31:3];
        ca.fields.rsvd      = '0;
        ca.fields.addr_lo   = addr_q[2:0];
    end

    always_comb begin
        dq_o   = '0;
        rwds_o = '0;
        case (phase_i)
            CMD: begin
                if (beat_sel_i != 2'd3) begin
                    dq_o = ca.beats[beat_sel_i];
                end
            end
            WRITE: begin
                if (tx_valid_i) begin
                    dq_o   = tx_data_i;
                    rwds_o = ~tx_strb_i;  // strobe high means byte written
                end else begin
                    rwds_o = 2'b11;  // no data this beat
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/hyper_trans_fsm.sv
`timescale 1ns/1ps

module hyper_trans_fsm #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned RX_DEPTH    = 16
) (
    input  logic                                 clk0,
    input  logic                                 rst_ni,
    input  logic                                 trans_valid_i,
    output logic                                 trans_ready_o,
    input  logic                                 write_i,
    input  logic [hyper_pkg::HYPER_BURST_W-1:0]  burst_i,
    input  logic [$clog2(RX_DEPTH+1)-1:0]        rx_space_i,
    input  logic                                 wait_done_i,
    input  logic                                 burst_done_i,
    output logic                                 wait_load_o,
    output logic [hyper_pkg::HYPER_WAIT_W-1:0]   wait_val_o,
    output logic                                 burst_load_o,
    output logic                                 beat_en_o,
    output logic                                 capture_o,
    output hyper_pkg::hyper_phase_e              phase_o,
    output logic [1:0]                           beat_sel_o,
    output logic                                 ck_en_o,
    output logic                                 dq_oe_o,
    output logic                                 rwds_oe_o,
    output logic                                 tx_ready_o,
    output logic                                 rx_push_o,
    input  logic                                 pad_rwds_i
);
    import hyper_pkg::*;

    localparam logic [HYPER_WAIT_W-1:0] LAT_VAL = HYPER_WAIT_W'(2 * WAIT_CYCLES - 1);
    localparam logic [HYPER_WAIT_W-1:0] REC_VAL = HYPER_WAIT_W'(WAIT_CYCLES - 1);

    hyper_phase_e phase_q;
    hyper_phase_e phase_d;
    logic [1:0]   beat_q;
    logic         trans_seen_q;  // valid was up last idle cycle, tx path holds it
    logic         room;
    logic         cmd_last;
    logic         last_beat;

    // a read must fit in the fifo before it starts, the bus cannot stall
    assign room = write_i || (burst_i <= HYPER_BURST_W'(rx_space_i));

    assign trans_ready_o = (phase_q == IDLE) && trans_valid_i && trans_seen_q && room;
    assign capture_o     = (phase_q == IDLE);

    assign cmd_last  = (phase_q == CMD) && (beat_q == 2'd2);
    assign beat_en_o = (phase_q == WRITE) || ((phase_q == READ) && pad_rwds_i);
    assign last_beat = beat_en_o && burst_done_i;

    assign wait_load_o  = cmd_last || last_beat;
    assign wait_val_o   = (phase_q == CMD) ? LAT_VAL : REC_VAL;
    assign burst_load_o = cmd_last;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            IDLE:    if (trans_ready_o) phase_d = CMD;
            CMD:     if (cmd_last) phase_d = LATENCY;
            LATENCY: if (wait_done_i) phase_d = write_i ? WRITE : READ;
            WRITE,
            READ:    if (last_beat) phase_d = RECOVER;
            RECOVER: if (wait_done_i) phase_d = IDLE;
            default: phase_d = IDLE;
        endcase
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q      <= IDLE;
            beat_q       <= 2'd0;
            trans_seen_q <= 1'b0;
        end else begin
            phase_q      <= phase_d;
            trans_seen_q <= (phase_q == IDLE) && trans_valid_i;
            if (phase_q == CMD) begin
                beat_q <= beat_q + 2'd1;
            end else begin
                beat_q <= 2'd0;
            end
        end
    end

    assign phase_o    = phase_q;
    assign beat_sel_o = beat_q;

    // pad controls decoded straight from the phase register
    assign ck_en_o    = phase_q inside {CMD, LATENCY, WRITE, READ};
    assign dq_oe_o    = phase_q inside {CMD, WRITE};
    assign rwds_oe_o  = (phase_q == WRITE);
    assign tx_ready_o = (phase_q == WRITE);
    assign rx_push_o  = (phase_q == READ) && pad_rwds_i;

    idle_not_data_a: assert property (@(posedge clk0) disable iff (!rst_ni)
        (phase_q == IDLE) |=> !(phase_q inside {WRITE, READ}));

    // whole read burst must fit in the receive fifo
    read_fits_a: assert property (@(posedge clk0) disable iff (!rst_ni)
        (phase_q == LATENCY && phase_d == READ) |-> (burst_i <= RX_DEPTH));

endmodule

// File: hdl/hyper_rx_fifo.sv
`timescale 1ns/1ps

module hyper_rx_fifo #(
    parameter int unsigned RX_DEPTH = 16
) (
    input  logic                           clk0,
    input  logic                           rst_ni,
    input  logic                           push_i,
    input  logic [15:0]                    data_i,
    output logic                           rx_valid_o,
    output logic [15:0]                    rx_data_o,
    input  logic                           rx_ready_i,
    output logic [$clog2(RX_DEPTH+1)-1:0]  space_o
);

    localparam int unsigned PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(RX_DEPTH + 1);

    logic [15:0]      mem_q [RX_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RX_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pop = rx_valid_o && rx_ready_i;

    always_ff @(posedge clk0) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    assign rx_valid_o = (count_q != '0);
    assign rx_data_o  = mem_q[rd_ptr_q];  // head word, holds until popped
    assign space_o    = CNT_W'(RX_DEPTH) - count_q;

    no_push_full_a: assert property (@(posedge clk0) disable iff (!rst_ni)
        push_i |-> (count_q != CNT_W'(RX_DEPTH)));

endmodule

// File: hdl/hyper_phy.sv
`timescale 1ns/1ps

module hyper_phy #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned RX_DEPTH    = 16
) (
    input  logic                       clk0,
    input  logic                       rst_ni,
    // transaction requests
    input  logic                       trans_valid_i,
    input  hyper_pkg::hyper_trans_t    trans_i,
    output logic                       trans_ready_o,
    // write data
    input  logic                       tx_valid_i,
    input  logic [15:0]                tx_data_i,
    input  logic [1:0]                 tx_strb_i,
    output logic                       tx_ready_o,
    // read data
    output logic                       rx_valid_o,
    output logic [15:0]                rx_data_o,
    input  logic                       rx_ready_i,
    // device pads, one word per clk0
    output hyper_pkg::hyper_pad_out_t  pad_o,
    input  hyper_pkg::hyper_pad_in_t   pad_i
);
    import hyper_pkg::*;

    hyper_phase_e                  phase;
    logic [1:0]                    beat_sel;
    logic                          capture;
    logic                          latched_write;
    logic [HYPER_BURST_W-1:0]      latched_burst;
    logic                          wait_load;
    logic [HYPER_WAIT_W-1:0]       wait_val;
    logic                          wait_done;
    logic                          burst_load;
    logic                          burst_done;
    logic                          beat_en;
    logic                          rx_push;
    logic [$clog2(RX_DEPTH+1)-1:0] rx_space;

    hyper_trans_fsm #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .RX_DEPTH    (RX_DEPTH)
    ) u_fsm (
        .clk0          (clk0),
        .rst_ni        (rst_ni),
        .trans_valid_i (trans_valid_i),
        .trans_ready_o (trans_ready_o),
        .write_i       (latched_write),
        .burst_i       (latched_burst),
        .rx_space_i    (rx_space),
        .wait_done_i   (wait_done),
        .burst_done_i  (burst_done),
        .wait_load_o   (wait_load),
        .wait_val_o    (wait_val),
        .burst_load_o  (burst_load),
        .beat_en_o     (beat_en),
        .capture_o     (capture),
        .phase_o       (phase),
        .beat_sel_o    (beat_sel),
        .ck_en_o       (pad_o.ck_en),
        .dq_oe_o       (pad_o.dq_oe),
        .rwds_oe_o     (pad_o.rwds_oe),
        .tx_ready_o    (tx_ready_o),
        .rx_push_o     (rx_push),
        .pad_rwds_i    (pad_i.rwds)
    );

    hyper_timer u_timer (
        .clk0         (clk0),
        .rst_ni       (rst_ni),
        .wait_load_i  (wait_load),
        .wait_val_i   (wait_val),
        .burst_load_i (burst_load),
        .burst_i      (latched_burst),
        .beat_en_i    (beat_en),
        .wait_done_o  (wait_done),
        .burst_done_o (burst_done)
    );

    hyper_tx_path u_tx_path (
        .clk0       (clk0),
        .rst_ni     (rst_ni),
        .capture_i  (capture),
        .trans_i    (trans_i),
        .phase_i    (phase),
        .beat_sel_i (beat_sel),
        .tx_valid_i (tx_valid_i),
        .tx_data_i  (tx_data_i),
        .tx_strb_i  (tx_strb_i),
        .cs_o       (pad_o.cs_n),
        .write_o    (latched_write),
        .burst_o    (latched_burst),
        .dq_o       (pad_o.dq),
        .rwds_o     (pad_o.rwds)
    );

    hyper_rx_fifo #(
        .RX_DEPTH (RX_DEPTH)
    ) u_rx_fifo (
        .clk0       (clk0),
        .rst_ni     (rst_ni),
        .push_i     (rx_push),
        .data_i     (pad_i.dq),
        .rx_valid_o (rx_valid_o),
        .rx_data_o  (rx_data_o),
        .rx_ready_i (rx_ready_i),
        .space_o    (rx_space)
    );

endmodule

// File: sim/hyper_mem_model.sv
`timescale 1ns/1ps

module hyper_mem_model #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned MEM_WORDS   = 512
) (
    input  logic                       clk0,
    input  hyper_pkg::hyper_pad_out_t  bus_i,
    output hyper_pkg::hyper_pad_in_t   bus_o
);
    import hyper_pkg::*;

    logic [15:0]   mem [HYPER_NR_CS][MEM_WORDS];  // loaded by the testbench at time 0
    hyper_ca_u     ca;
    hyper_pad_in_t drive_q = '0;
    logic          reading = 1'b0;  // read data window open
    int            beat = 0;
    int            lat = 0;
    int            sel = 0;
    int            addr = 0;

    assign bus_o = drive_q;

    // device samples the bus on the rising edge
    always @(posedge clk0) begin
        if (&bus_i.cs_n) begin
            beat    = 0;  // deselected, wait for the next command
            lat     = 0;
            reading = 1'b0;
        end else if (beat < 3) begin
            ca.beats[beat] = bus_i.dq;
            beat++;
            if (beat == 3) begin
                sel  = bus_i.cs_n[0] ? 1 : 0;
                addr = int'({ca.fields.addr_hi, ca.fields.addr_lo}) % MEM_WORDS;
                lat  = 2 * WAIT_CYCLES;
            end
        end else if (lat != 0) begin
            lat--;
            reading = ca.fields.rw_n && (lat == 0);
        end else if (reading) begin
            if (drive_q.rwds) addr = (addr + 1) % MEM_WORDS;  // word taken by the core
        end else if (bus_i.rwds_oe) begin
            // rwds high masks the byte
            if (!bus_i.rwds[0]) mem[sel][addr][7:0] = bus_i.dq[7:0];
            if (!bus_i.rwds[1]) mem[sel][addr][15:8] = bus_i.dq[15:8];
            addr = (addr + 1) % MEM_WORDS;
        end
    end

    // read words go out with random gaps where rwds stays low
    always @(negedge clk0) begin
        drive_q.rwds = reading && (($urandom % 4) != 0);
        drive_q.dq   = drive_q.rwds ? mem[sel][addr] : 16'($urandom);  // junk in gaps
    end

endmodule

// File: sim/tb_hyper_phy.sv
`timescale 1ns/1ps

module tb_hyper_phy;
    import hyper_pkg::*;

    localparam int unsigned WAIT_CYCLES = 6;
    localparam int unsigned RX_DEPTH    = 16;
    localparam int unsigned NUM_TRANS   = 60;
    localparam int unsigned MEM_WORDS   = 512;
    localparam int          WR_START    = 4 + 2 * WAIT_CYCLES;  // first data cycle after accept
    localparam int unsigned TIMEOUT_CYC = NUM_TRANS * 200;

    logic           clk0 = 1'b0;
    logic           rst_ni = 1'b0;
    logic           trans_valid_i = 1'b0;
    hyper_trans_t   trans_i = '0;
    logic           trans_ready_o;
    logic           tx_valid_i = 1'b0;
    logic [15:0]    tx_data_i = '0;
    logic [1:0]     tx_strb_i = '0;
    logic           tx_ready_o;
    logic           rx_valid_o;
    logic [15:0]    rx_data_o;
    logic           rx_ready_i = 1'b0;
    hyper_pad_out_t pad_o;
    hyper_pad_in_t  pad_i;

    logic [15:0]  ref_mem [HYPER_NR_CS][MEM_WORDS];
    logic [15:0]  exp_q [$];  // read words not yet popped
    hyper_trans_t cur = '0;   // transaction on the bus
    hyper_ca_u    ca;
    int           cyc = 100000;  // cycles since the accept edge
    int           cs_gap = WAIT_CYCLES;
    int           checks = 0;
    int           errors = 0;

    hyper_phy #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .RX_DEPTH    (RX_DEPTH)
    ) dut (.*);

    hyper_mem_model #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .MEM_WORDS   (MEM_WORDS)
    ) mem_dev (
        .clk0  (clk0),
        .bus_i (pad_o),
        .bus_o (pad_i)
    );

    always #2 clk0 = ~clk0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    // write data and read back-pressure change every cycle
    always @(negedge clk0) begin
        tx_valid_i = ($urandom % 4) != 0;
        tx_data_i  = 16'($urandom);
        tx_strb_i  = 2'($urandom);
        rx_ready_i = ($urandom % 3) == 0;
    end

    always @(posedge clk0) begin : monitor
        logic       in_cmd;
        logic       in_wr;
        logic [1:0] mask;
        int         idx;
        int         pending;
        if (rst_ni) begin
            cyc++;
            pending = exp_q.size();  // fifo level the core sees at this edge
            in_cmd  = (cyc >= 1) && (cyc <= 3);
            in_wr   = cur.write && (cyc >= WR_START) && (cyc < WR_START + int'(cur.burst));
            check_value("tx_ready_o", 32'(tx_ready_o), 32'(in_wr));
            check_value("pad_o.rwds_oe", 32'(pad_o.rwds_oe), 32'(in_wr));
            check_value("pad_o.dq_oe", 32'(pad_o.dq_oe), 32'(in_cmd || in_wr));
            if (in_cmd) begin
                check_value("pad_o.cs_n", {30'd0, pad_o.cs_n}, {30'd0, ~cur.cs});
                check_value("pad_o.ck_en", 32'(pad_o.ck_en), 32'd1);
                ca.beats[cyc - 1] = pad_o.dq;
            end
            if (cyc == 3) begin
                check_value("ca.rw_n", 32'(ca.fields.rw_n), 32'(!cur.write));
                check_value("ca.reg_space", 32'(ca.fields.reg_space), 32'd0);
                check_value("ca.linear", 32'(ca.fields.linear), 32'd1);
                check_value("ca.address", {ca.fields.addr_hi, ca.fields.addr_lo}, cur.address);
            end
            if (in_wr) begin
                mask = tx_valid_i ? ~tx_strb_i : 2'b11;
                idx  = (int'(cur.address) + cyc - WR_START) % MEM_WORDS;
                check_value("pad_o.rwds", 32'(pad_o.rwds), 32'(mask));
                if (tx_valid_i) check_value("pad_o.dq", 32'(pad_o.dq), 32'(tx_data_i));
                if (!mask[0]) ref_mem[cur.cs[1]][idx][7:0] = tx_data_i[7:0];
                if (!mask[1]) ref_mem[cur.cs[1]][idx][15:8] = tx_data_i[15:8];
            end
            if (&pad_o.cs_n) begin
                cs_gap++;
                check_value("pad_o.ck_en", 32'(pad_o.ck_en), 32'd0);  // no clock while deselected
            end else begin
                if (cs_gap != 0 && cs_gap < WAIT_CYCLES) begin
                    report_failure($sformatf("cs_n high for only %0d cycles", cs_gap));
                end
                cs_gap = 0;
            end
            if (rx_valid_o && rx_ready_i) begin
                if (exp_q.size() == 0) report_failure("read word popped with no read pending");
                else check_value("rx_data_o", 32'(rx_data_o), 32'(exp_q.pop_front()));
            end
            if (trans_valid_i && trans_ready_o) begin
                if (!trans_i.write && pending + int'(trans_i.burst) > RX_DEPTH) begin
                    report_failure("read accepted without room for its burst in the FIFO");
                end
                for (int i = 0; i < int'(trans_i.burst) && !trans_i.write; i++) begin
                    idx = (int'(trans_i.address) + i) % MEM_WORDS;
                    exp_q.push_back(ref_mem[trans_i.cs[1]][idx]);
                end
                cur = trans_i;
                cyc = 0;
            end
        end
    end

    initial begin
        hyper_trans_t t;
        void'($urandom(32'h67e2f99f));
        for (int c = 0; c < HYPER_NR_CS; c++) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                ref_mem[c][a]     = 16'((a * 32'h2f1b) ^ (c << 12) ^ (a >> 4));
                mem_dev.mem[c][a] = ref_mem[c][a];
            end
        end
        repeat (3) @(posedge clk0);
        @(negedge clk0);
        rst_ni = 1'b1;
        @(posedge clk0);
        check_value("trans_ready_o", 32'(trans_ready_o), 32'd0);
        check_value("rx_valid_o", 32'(rx_valid_o), 32'd0);
        check_value("pad_o.cs_n", {30'd0, pad_o.cs_n}, 32'h3);
        check_value("pad_o.ck_en", 32'(pad_o.ck_en), 32'd0);
        for (int n = 0; n < NUM_TRANS; n++) begin
            t.cs      = (($urandom % 2) == 0) ? 2'b01 : 2'b10;
            t.write   = 1'($urandom);
            t.address = $urandom % 256;
            t.burst   = HYPER_BURST_W'(1 + $urandom % 8);
            @(negedge clk0);
            trans_valid_i = 1'b1;
            trans_i       = t;
            do @(posedge clk0); while (!trans_ready_o);
        end
        @(negedge clk0);
        trans_valid_i = 1'b0;
        // last burst finished and every read word popped
        do @(posedge clk0); while (cyc < 4 || !(&pad_o.cs_n) || exp_q.size() != 0);
        repeat (WAIT_CYCLES) @(posedge clk0);
        check_value("rx_valid_o", 32'(rx_valid_o), 32'd0);  // no extra words
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk0);
        $display("timeout after %0d cycles, %0d checks, %0d errors", TIMEOUT_CYC, checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: filelist.f
hdl/hyper_pkg.sv
hdl/hyper_timer.sv
hdl/hyper_tx_path.sv
hdl/hyper_trans_fsm.sv
hdl/hyper_rx_fifo.sv
hdl/hyper_phy.sv
sim/hyper_mem_model.sv
sim/tb_hyper_phy.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hyper_phy
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
